// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_core_pkg.sv
  - design/rv_regfile.sv
  - design/rv_decode.sv
  - design/rv_execute.sv
  - design/rv_debug_unit.sv
  - design/rv_core.sv
  - target: test
    files:
      - test/rv_core_tb.sv

// ==== design/rv_core.sv ====
/*
  RV32I integer core top: ID, EX, register file and debug unit.
  No PC and no memory stage; instructions arrive already fetched.
  Results are visible in the register file three edges after acceptance.
*/
`default_nettype none

module rv_core #(
  parameter int REG_COUNT = 32  // 16 for rv32e
)(
  input  logic                         clk,
  input  logic                         rstn,
  input  logic [rv_core_pkg::ILEN-1:0] instr_i,
  input  logic                         instr_valid_i,
  output logic                         instr_stall_o,
  input  logic                         dbg_stall_i,
  input  logic                         dbg_strb_i,
  input  logic                         dbg_we_i,
  input  rv_core_pkg::reg_idx_t        dbg_addr_i,
  input  rv_core_pkg::xlen_t           dbg_dati_i,
  output rv_core_pkg::xlen_t           dbg_dato_o,
  output logic                         dbg_ack_o,
  output logic                         dbg_halted_o
);
  import rv_core_pkg::*;

  //////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////
  logic     id_valid;
  alu_op_e  id_alu_op;
  xlen_t    id_opa;
  xlen_t    id_opb;
  reg_idx_t id_dst;
  logic     ex_valid;   // also rf write enable
  reg_idx_t ex_dst;
  xlen_t    ex_r;
  reg_idx_t rf_src1;
  reg_idx_t rf_src2;
  xlen_t    rf_srcv1;
  xlen_t    rf_srcv2;
  logic     du_stall;
  logic     du_we_rf;
  reg_idx_t du_addr;
  xlen_t    du_dato;
  xlen_t    du_dati_rf;

  assign instr_stall_o = du_stall;  // only source of back-pressure

  rv_decode #(
    .REG_COUNT ( REG_COUNT )
  ) u_decode (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .instr_i       ( instr_i       ),
    .instr_valid_i ( instr_valid_i ),
    .du_stall_i    ( du_stall      ),
    .rf_srcv1_i    ( rf_srcv1      ),
    .rf_srcv2_i    ( rf_srcv2      ),
    .ex_valid_i    ( ex_valid      ),  // bypass
    .ex_dst_i      ( ex_dst        ),
    .ex_r_i        ( ex_r          ),
    .rf_src1_o     ( rf_src1       ),
    .rf_src2_o     ( rf_src2       ),
    .id_valid_o    ( id_valid      ),
    .id_alu_op_o   ( id_alu_op     ),
    .id_opa_o      ( id_opa        ),
    .id_opb_o      ( id_opb        ),
    .id_dst_o      ( id_dst        )
  );

  rv_execute u_execute (
    .clk         ( clk       ),
    .rstn        ( rstn      ),
    .id_valid_i  ( id_valid  ),
    .id_alu_op_i ( id_alu_op ),
    .id_opa_i    ( id_opa    ),
    .id_opb_i    ( id_opb    ),
    .id_dst_i    ( id_dst    ),
    .ex_valid_o  ( ex_valid  ),
    .ex_dst_o    ( ex_dst    ),
    .ex_r_o      ( ex_r      )
  );

  rv_regfile #(
    .REG_COUNT ( REG_COUNT )
  ) u_regfile (
    .clk          ( clk        ),
    .rstn         ( rstn       ),
    .rf_src1_i    ( rf_src1    ),
    .rf_src2_i    ( rf_src2    ),
    .rf_srcv1_o   ( rf_srcv1   ),
    .rf_srcv2_o   ( rf_srcv2   ),
    .rf_we_i      ( ex_valid   ),  // write-back straight from EX register
    .rf_dst_i     ( ex_dst     ),
    .rf_dstv_i    ( ex_r       ),
    .du_we_rf_i   ( du_we_rf   ),
    .du_addr_i    ( du_addr    ),
    .du_dato_i    ( du_dato    ),
    .du_dati_rf_o ( du_dati_rf )
  );

  rv_debug_unit u_debug (
    .clk          ( clk          ),
    .rstn         ( rstn         ),
    .dbg_stall_i  ( dbg_stall_i  ),
    .dbg_strb_i   ( dbg_strb_i   ),
    .dbg_we_i     ( dbg_we_i     ),
    .dbg_addr_i   ( dbg_addr_i   ),
    .dbg_dati_i   ( dbg_dati_i   ),
    .dbg_dato_o   ( dbg_dato_o   ),
    .dbg_ack_o    ( dbg_ack_o    ),
    .dbg_halted_o ( dbg_halted_o ),
    .id_valid_i   ( id_valid     ),
    .ex_valid_i   ( ex_valid     ),
    .du_dati_rf_i ( du_dati_rf   ),
    .du_stall_o   ( du_stall     ),
    .du_we_rf_o   ( du_we_rf     ),
    .du_addr_o    ( du_addr      ),
    .du_dato_o    ( du_dato      )
  );

endmodule

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
/*
  Shared widths, opcodes and ALU encodings for the RV32I integer pipe.
  Only the OP, OP-IMM and LUI major opcodes are decoded; everything else
  travels down the pipe as a bubble.
*/
`default_nettype none

package rv_core_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int XLEN       = 32;  // data word
  localparam int ILEN       = 32;  // instruction word, no compressed
  localparam int REG_ADDR_W = 5;   // x0..x31 index

  typedef logic [REG_ADDR_W-1:0] reg_idx_t;  // register index
  typedef logic [XLEN-1:0]       xlen_t;     // data word

  //////////////////////////////////////////////////
  // major opcodes, instr[6:0]
  //////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // reg-reg alu
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
  localparam logic [6:0] OPC_LUI    = 7'b0110111;  // upper immediate

  //////////////////////////////////////////////////
  // alu operations
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,   // signed compare
    ALU_SLTU  = 4'd9,   // unsigned compare
    ALU_PASSB = 4'd10   // lui, operand b straight through
  } alu_op_e;

endpackage

`default_nettype wire

// ==== design/rv_debug_unit.sv ====
/*
  Debug unit: halt tracking plus one pending register access.
  A strobe is latched and served on the first edge the core is halted;
  dbg_ack_o pulses one cycle later. A new strobe overrides a pending one.
*/
`default_nettype none

module rv_debug_unit (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  dbg_stall_i,
  input  logic                  dbg_strb_i,
  input  logic                  dbg_we_i,
  input  rv_core_pkg::reg_idx_t dbg_addr_i,
  input  rv_core_pkg::xlen_t    dbg_dati_i,
  output rv_core_pkg::xlen_t    dbg_dato_o,
  output logic                  dbg_ack_o,
  output logic                  dbg_halted_o,
  input  logic                  id_valid_i,
  input  logic                  ex_valid_i,
  input  rv_core_pkg::xlen_t    du_dati_rf_i,
  output logic                  du_stall_o,
  output logic                  du_we_rf_o,
  output rv_core_pkg::reg_idx_t du_addr_o,
  output rv_core_pkg::xlen_t    du_dato_o
);
  import rv_core_pkg::*;

  logic     pend_q;       // request waiting for halt
  logic     pend_we_q;
  reg_idx_t pend_addr_q;
  xlen_t    pend_dat_q;
  logic     serve;

  assign serve = dbg_halted_o & pend_q;

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      dbg_halted_o <= 1'b0;
      pend_q       <= 1'b0;
      pend_we_q    <= 1'b0;
      dbg_ack_o    <= 1'b0;
    end
    else
    begin
      dbg_halted_o <= dbg_stall_i & ~id_valid_i & ~ex_valid_i;  // pipe drained
      dbg_ack_o    <= serve;                                    // single pulse
      if (dbg_strb_i)
      begin
        pend_q    <= 1'b1;
        pend_we_q <= dbg_we_i;
      end
      else if (serve) pend_q <= 1'b0;
    end
  end

  // request payload and read data
  always_ff @(posedge clk)
  begin
    if (dbg_strb_i)
    begin
      pend_addr_q <= dbg_addr_i;
      pend_dat_q  <= dbg_dati_i;
    end
    if (serve) dbg_dato_o <= du_dati_rf_i;  // held until the next ack
  end

  assign du_stall_o = dbg_stall_i | dbg_halted_o;  // no fetch while halting or halted
  assign du_we_rf_o = serve & pend_we_q;
  assign du_addr_o  = pend_addr_q;
  assign du_dato_o  = pend_dat_q;

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
/*
  ID stage; instruction capture is folded in here, there is no PC.
  Unsupported encodings and register indices at or above REG_COUNT leave
  as a bubble. Only the EX result is bypassed; the RF covers the rest.
*/
`default_nettype none

module rv_decode #(
  parameter int REG_COUNT = 32
)(
  input  logic                           clk,
  input  logic                           rstn,
  input  logic [rv_core_pkg::ILEN-1:0]   instr_i,
  input  logic                           instr_valid_i,
  input  logic                           du_stall_i,
  input  rv_core_pkg::xlen_t             rf_srcv1_i,
  input  rv_core_pkg::xlen_t             rf_srcv2_i,
  input  logic                           ex_valid_i,
  input  rv_core_pkg::reg_idx_t          ex_dst_i,
  input  rv_core_pkg::xlen_t             ex_r_i,
  output rv_core_pkg::reg_idx_t          rf_src1_o,
  output rv_core_pkg::reg_idx_t          rf_src2_o,
  output logic                           id_valid_o,
  output rv_core_pkg::alu_op_e           id_alu_op_o,
  output rv_core_pkg::xlen_t             id_opa_o,
  output rv_core_pkg::xlen_t             id_opb_o,
  output rv_core_pkg::reg_idx_t          id_dst_o
);
  import rv_core_pkg::*;

  logic [ILEN-1:0] instr_q;      // captured instruction
  logic            instr_vld_q;  // low = bubble
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;       // sub / sra marker
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  reg_idx_t        rd;
  logic            legal;
  logic            use_rs1;
  logic            use_rs2;
  logic            regs_ok;
  logic            byp1;
  logic            byp2;
  xlen_t           imm;
  alu_op_e         alu_op;

  //////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn) instr_vld_q <= 1'b0;
    else       instr_vld_q <= instr_valid_i & ~du_stall_i;  // bubble while halting
  end

  always_ff @(posedge clk)
  begin
    if (instr_valid_i && !du_stall_i) instr_q <= instr_i;
  end

  //////////////////////////////////////////////////
  // field decode
  //////////////////////////////////////////////////
  assign opcode  = instr_q[6:0];
  assign rd      = instr_q[11:7];
  assign funct3  = instr_q[14:12];
  assign rs1     = instr_q[19:15];
  assign rs2     = instr_q[24:20];
  assign funct7  = instr_q[31:25];
  assign f7_zero = (funct7 == 7'h00);
  assign f7_alt  = (funct7 == 7'h20);

  always_comb
  begin
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    alu_op  = ALU_ADD;
    imm     = {{20{instr_q[31]}}, instr_q[31:20]};  // I-type, sign extended

    case (opcode)
      OPC_OP:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        legal   = f7_zero;
        case (funct3)
          3'b000:
          begin
            alu_op = f7_alt ? ALU_SUB : ALU_ADD;
            legal  = f7_zero | f7_alt;
          end
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:
          begin
            alu_op = f7_alt ? ALU_SRA : ALU_SRL;
            legal  = f7_zero | f7_alt;
          end
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_OP_IMM:
      begin
        use_rs1 = 1'b1;
        legal   = 1'b1;
        case (funct3)
          3'b000:  alu_op = ALU_ADD;
          3'b001:
          begin
            alu_op = ALU_SLL;
            legal  = f7_zero;  // shamt[5] must be clear on rv32
          end
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:
          begin
            alu_op = f7_alt ? ALU_SRA : ALU_SRL;
            legal  = f7_zero | f7_alt;
          end
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_LUI:
      begin
        legal  = 1'b1;
        alu_op = ALU_PASSB;
        imm    = {instr_q[31:12], 12'h000};  // U-type
      end
      default: legal = 1'b0;  // loads, branches, system ... -> bubble
    endcase
  end

  // rv32e style check, only fields actually used count
  assign regs_ok = (rd < REG_COUNT) &&
                   (!use_rs1 || rs1 < REG_COUNT) &&
                   (!use_rs2 || rs2 < REG_COUNT);

  //////////////////////////////////////////////////
  // operands, bypass from EX register
  //////////////////////////////////////////////////
  assign rf_src1_o = rs1;
  assign rf_src2_o = rs2;
  assign byp1      = ex_valid_i && (ex_dst_i == rs1) && (rs1 != '0);
  assign byp2      = ex_valid_i && (ex_dst_i == rs2) && (rs2 != '0);

  assign id_opa_o    = byp1 ? ex_r_i : rf_srcv1_i;
  assign id_opb_o    = use_rs2 ? (byp2 ? ex_r_i : rf_srcv2_i) : imm;
  assign id_alu_op_o = alu_op;
  assign id_dst_o    = rd;
  assign id_valid_o  = instr_vld_q & legal & regs_ok & (rd != '0);  // x0 dst -> no write

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
/*
  EX stage: single-cycle integer ALU and the EX result register.
  Shift amount is operand B[4:0]; the result register feeds both write-back
  and the decode bypass.
*/
`default_nettype none

module rv_execute (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  id_valid_i,
  input  rv_core_pkg::alu_op_e  id_alu_op_i,
  input  rv_core_pkg::xlen_t    id_opa_i,
  input  rv_core_pkg::xlen_t    id_opb_i,
  input  rv_core_pkg::reg_idx_t id_dst_i,
  output logic                  ex_valid_o,
  output rv_core_pkg::reg_idx_t ex_dst_o,
  output rv_core_pkg::xlen_t    ex_r_o
);
  import rv_core_pkg::*;

  logic [4:0] shamt;   // rv32 shift range
  xlen_t      alu_r;

  assign shamt = id_opb_i[4:0];

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb
  begin
    case (id_alu_op_i)
      ALU_ADD:   alu_r = id_opa_i + id_opb_i;
      ALU_SUB:   alu_r = id_opa_i - id_opb_i;
      ALU_AND:   alu_r = id_opa_i & id_opb_i;
      ALU_OR:    alu_r = id_opa_i | id_opb_i;
      ALU_XOR:   alu_r = id_opa_i ^ id_opb_i;
      ALU_SLL:   alu_r = id_opa_i << shamt;
      ALU_SRL:   alu_r = id_opa_i >> shamt;
      ALU_SRA:   alu_r = $signed(id_opa_i) >>> shamt;  // sign fill
      ALU_SLT:   alu_r = xlen_t'($signed(id_opa_i) < $signed(id_opb_i));
      ALU_SLTU:  alu_r = xlen_t'(id_opa_i < id_opb_i);
      ALU_PASSB: alu_r = id_opb_i;                     // lui
      default:   alu_r = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // EX register
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn) ex_valid_o <= 1'b0;
    else       ex_valid_o <= id_valid_i;  // bubbles pass as invalid
  end

  always_ff @(posedge clk)
  begin
    ex_dst_o <= id_dst_i;
    ex_r_o   <= alu_r;
  end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
/*
  Integer register file, REG_COUNT words, x0 hard-wired to zero.
  Two combinational read ports, one pipeline write port, one debug port.
  Debug writes only happen while the pipe is drained, so the pipeline
  write wins if both are ever raised together.
*/
`default_nettype none

module rv_regfile #(
  parameter int REG_COUNT = 32
)(
  input  logic                  clk,
  input  logic                  rstn,
  input  rv_core_pkg::reg_idx_t rf_src1_i,
  input  rv_core_pkg::reg_idx_t rf_src2_i,
  output rv_core_pkg::xlen_t    rf_srcv1_o,
  output rv_core_pkg::xlen_t    rf_srcv2_o,
  input  logic                  rf_we_i,
  input  rv_core_pkg::reg_idx_t rf_dst_i,
  input  rv_core_pkg::xlen_t    rf_dstv_i,
  input  logic                  du_we_rf_i,
  input  rv_core_pkg::reg_idx_t du_addr_i,
  input  rv_core_pkg::xlen_t    du_dato_i,
  output rv_core_pkg::xlen_t    du_dati_rf_o
);
  import rv_core_pkg::*;

  xlen_t regs [REG_COUNT];

  always_ff @(posedge clk, negedge rstn)
  begin
    if (!rstn)
    begin
      for (int i = 0; i < REG_COUNT; i++) regs[i] <= '0;  // all zero out of reset
    end
    else if (rf_we_i && rf_dst_i != '0 && rf_dst_i < REG_COUNT)
      regs[rf_dst_i] <= rf_dstv_i;                         // write-back
    else if (du_we_rf_i && du_addr_i != '0 && du_addr_i < REG_COUNT)
      regs[du_addr_i] <= du_dato_i;                        // debug write
  end

  // x0 and out-of-range indices read as zero
  assign rf_srcv1_o   = (rf_src1_i != '0 && rf_src1_i < REG_COUNT) ? regs[rf_src1_i] : '0;
  assign rf_srcv2_o   = (rf_src2_i != '0 && rf_src2_i < REG_COUNT) ? regs[rf_src2_i] : '0;
  assign du_dati_rf_o = (du_addr_i != '0 && du_addr_i < REG_COUNT) ? regs[du_addr_i] : '0;

endmodule

`default_nettype wire

// ==== rv_core.f ====
design/rv_core_pkg.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_debug_unit.sv
design/rv_core.sv
test/rv_core_tb.sv

// ==== test/rv_core_tb.sv ====
/*
  Testbench for rv_core with REG_COUNT 32. Inputs change on the falling edge.
  The register model is updated when an instruction is presented, so the
  core must be drained (halted) before any compare through the debug port.
*/
`default_nettype none

module rv_core_tb;

  logic        clk;
  logic        rstn;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        instr_stall_o;
  logic        dbg_stall_i;
  logic        dbg_strb_i;
  logic        dbg_we_i;
  logic [4:0]  dbg_addr_i;
  logic [31:0] dbg_dati_i;
  logic [31:0] dbg_dato_o;
  logic        dbg_ack_o;
  logic        dbg_halted_o;

  logic [31:0] model_regs [32];  // architectural state in program order
  logic [4:0]  last_rd;          // for dependent pairs
  int          err_cnt;
  int          test_err_base;
  int          ok_tests;
  int          bad_tests;

  rv_core #(
    .REG_COUNT ( 32 )
  ) u_dut (
    .clk           ( clk           ),
    .rstn          ( rstn          ),
    .instr_i       ( instr_i       ),
    .instr_valid_i ( instr_valid_i ),
    .instr_stall_o ( instr_stall_o ),
    .dbg_stall_i   ( dbg_stall_i   ),
    .dbg_strb_i    ( dbg_strb_i    ),
    .dbg_we_i      ( dbg_we_i      ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_dati_i    ( dbg_dati_i    ),
    .dbg_dato_o    ( dbg_dato_o    ),
    .dbg_ack_o     ( dbg_ack_o     ),
    .dbg_halted_o  ( dbg_halted_o  )
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // period 10
  end

  //////////////////////////////////////////////////
  // protocol checks
  //////////////////////////////////////////////////
  a_stall_out: assert property (@(posedge clk) disable iff (!rstn)
    dbg_stall_i |-> instr_stall_o)
    else begin $display("instr_stall_o low while dbg_stall_i is high"); err_cnt++; end

  a_no_stall: assert property (@(posedge clk) disable iff (!rstn)
    (!dbg_stall_i && !dbg_halted_o) |-> !instr_stall_o)
    else begin $display("instr_stall_o high with no halt requested"); err_cnt++; end

  a_halt_time: assert property (@(posedge clk) disable iff (!rstn)
    $rose(dbg_stall_i) |-> ##[1:3] dbg_halted_o)
    else begin $display("core did not halt within 3 cycles"); err_cnt++; end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack_o |=> !dbg_ack_o)
    else begin $display("dbg_ack_o longer than one cycle"); err_cnt++; end

  a_ack_halted: assert property (@(posedge clk) disable iff (!rstn)
    dbg_ack_o |-> dbg_halted_o)
    else begin $display("dbg_ack_o while the core is not halted"); err_cnt++; end

  //////////////////////////////////////////////////
  // encoders and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // illegal encodings and rd=x0 leave the model unchanged
  function automatic void model_exec(input logic [31:0] ins);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        ok;
    logic        is_op;
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    is_op = (opc == 7'b0110011);
    a     = model_regs[ins[19:15]];
    b     = is_op ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    r     = '0;
    ok    = 1'b1;
    if (opc == 7'b0110111)
      r = {ins[31:12], 12'h000};
    else if (is_op || opc == 7'b0010011)
    begin
      if (is_op)
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      else if (f3 == 3'd1)
        ok = (f7 == 7'h00);
      else if (f3 == 3'd5)
        ok = (f7 == 7'h00) || (f7 == 7'h20);
      case (f3)
        3'd0:
        begin
          if (is_op && f7 == 7'h20) r = a - b;
          else                      r = a + b;
        end
        3'd1: r = a << b[4:0];
        3'd2: r = {31'd0, $signed(a) < $signed(b)};
        3'd3: r = {31'd0, a < b};
        3'd4: r = a ^ b;
        3'd5:
        begin
          if (f7 == 7'h20) r = $signed(a) >>> b[4:0];  // arithmetic
          else             r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    else
      ok = 1'b0;  // load, branch, system ...
    if (ok && ins[11:7] != 5'd0) model_regs[ins[11:7]] = r;
  endfunction

  // random legal instruction that often reads the last rd
  function automatic logic [31:0] rand_alu_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          kind;
    rd   = 5'($urandom_range(0, 31));
    rs1  = ($urandom_range(0, 1) == 1) ? last_rd : 5'($urandom_range(0, 31));
    rs2  = ($urandom_range(0, 3) == 0) ? last_rd : 5'($urandom_range(0, 31));
    f3   = 3'($urandom_range(0, 7));
    kind = $urandom_range(0, 9);
    f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
    last_rd = rd;
    if (kind < 4)
      return enc_r(f7, rs2, rs1, f3, rd);
    if (kind == 9)
      return enc_lui(20'($urandom()), rd);
    if (f3 == 3'd1 || f3 == 3'd5)
      return enc_i({f7, 5'($urandom())}, rs1, f3, rd);  // shift immediates
    return enc_i(12'($urandom()), rs1, f3, rd);
  endfunction

  // load, store, branch, system or M-extension encodings
  function automatic logic [31:0] rand_bad_instr();
    logic [31:0] ins;
    ins = $urandom();
    case ($urandom_range(0, 4))
      0:       ins[6:0] = 7'b0000011;  // load
      1:       ins[6:0] = 7'b0100011;  // store
      2:       ins[6:0] = 7'b1100011;  // branch
      3:       ins[6:0] = 7'b1110011;  // system
      default: ins = enc_r(7'h01, ins[24:20], ins[19:15], ins[14:12], ins[11:7]);  // mul
    endcase
    return ins;
  endfunction

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////
  task automatic issue(input logic [31:0] ins);
    @(negedge clk);
    instr_i       = ins;
    instr_valid_i = 1'b1;
    model_exec(ins);
  endtask

  task automatic halt_core(input bit feed);
    int n;
    @(negedge clk);
    dbg_stall_i = 1'b1;
    n = 0;
    while (!dbg_halted_o && n < 10)
    begin
      instr_valid_i = feed;         // fed words must be ignored
      if (feed) instr_i = rand_alu_instr();
      @(negedge clk);
      n++;
    end
    if (!dbg_halted_o)
    begin
      $display("timeout: core never reported halted");
      err_cnt++;
    end
    instr_valid_i = 1'b0;
  endtask

  task automatic resume_core();
    int n;
    @(negedge clk);
    dbg_stall_i   = 1'b0;
    instr_valid_i = 1'b0;
    n = 0;
    while (dbg_halted_o && n < 10)
    begin
      @(negedge clk);
      n++;
    end
    if (dbg_halted_o)
    begin
      $display("timeout: core stayed halted after release");
      err_cnt++;
    end
  endtask

  task automatic debug_access(input bit we, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    @(negedge clk);
    dbg_strb_i = 1'b1;  // one-cycle request
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_dati_i = wdata;
    @(negedge clk);
    dbg_strb_i = 1'b0;
    n = 0;
    while (!dbg_ack_o && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    if (!dbg_ack_o)
    begin
      $display("timeout: debug access to x%0d was never acknowledged", addr);
      err_cnt++;
    end
    rdata = dbg_dato_o;  // held from the ack cycle
  endtask

  task automatic read_check(input string name, input logic [4:0] addr);
    logic [31:0] got;
    debug_access(1'b0, addr, 32'd0, got);
    assert (got === model_regs[addr])
    else
    begin
      $display("Error: %s x%0d expected %08h actual %08h", name, addr, model_regs[addr], got);
      err_cnt++;
    end
  endtask

  task automatic check_all_regs(input string name);
    for (int i = 0; i < 32; i++) read_check(name, 5'(i));
  endtask

  task automatic start_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base)
    begin
      $display("test %s: ok", name);
      ok_tests++;
    end
    else
    begin
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
      bad_tests++;
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  task automatic test_reset();
    start_test();
    assert ({dbg_ack_o, dbg_halted_o, instr_stall_o} === 3'b000)
    else
    begin
      $display("Error: reset ack/halted/stall expected 000 actual %03b",
               {dbg_ack_o, dbg_halted_o, instr_stall_o});
      err_cnt++;
    end
    halt_core(1'b0);
    check_all_regs("reset");
    resume_core();
    end_test("reset");
  endtask

  task automatic test_debug_rw();
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] unused;
    start_test();
    halt_core(1'b0);
    for (int k = 0; k < 10; k++)
    begin
      addr = (k == 0) ? 5'd0 : 5'($urandom_range(0, 31));  // x0 always covered
      data = $urandom();
      debug_access(1'b1, addr, data, unused);
      if (addr != 5'd0) model_regs[addr] = data;
      read_check("debug_rw", addr);
    end
    resume_core();
    end_test("debug_rw");
  endtask

  task automatic test_random_prog();
    start_test();
    for (int k = 0; k < 200; k++) issue(rand_alu_instr());  // back to back
    halt_core(1'b0);
    check_all_regs("random_prog");
    resume_core();
    end_test("random_prog");
  endtask

  task automatic test_unsupported();
    start_test();
    for (int k = 0; k < 90; k++)
    begin
      if (k % 3 == 2) issue(rand_bad_instr());
      else            issue(rand_alu_instr());
    end
    halt_core(1'b0);
    check_all_regs("unsupported");
    resume_core();
    end_test("unsupported");
  endtask

  task automatic test_halt();
    start_test();
    for (int k = 0; k < 20; k++) issue(rand_alu_instr());
    halt_core(1'b1);  // keep presenting words while stalled
    check_all_regs("halt");
    resume_core();
    end_test("halt");
  endtask

  task automatic test_writeback_path();
    logic [4:0] rd;
    start_test();
    for (int k = 0; k < 4; k++)
    begin
      rd = 5'($urandom_range(1, 31));
      issue(enc_i(12'($urandom()), rd, 3'd0, rd));  // addi rd, rd, imm
      @(negedge clk);
      instr_valid_i = 1'b0;
      dbg_stall_i   = 1'b1;   // halt right behind it
      read_check("writeback", rd);  // strobe latched before the halt
      resume_core();
    end
    end_test("writeback");
  endtask

  initial
  begin
    void'($urandom(50));
    rstn          = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    dbg_stall_i   = 1'b0;
    dbg_strb_i    = 1'b0;
    dbg_we_i      = 1'b0;
    dbg_addr_i    = '0;
    dbg_dati_i    = '0;
    last_rd       = '0;
    err_cnt       = 0;
    test_err_base = 0;
    ok_tests      = 0;
    bad_tests     = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    test_reset();
    test_debug_rw();
    test_random_prog();
    test_unsupported();
    test_halt();
    test_writeback_path();

    $display("summary: %0d tests ok, %0d tests failed, %0d errors",
             ok_tests, bad_tests, err_cnt);
    if (bad_tests == 0 && err_cnt == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
